// ==== rv_core.f ====
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
dv/tb_clock.sv
dv/tb_rv_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = rv_core.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module tb_rv_core;

    localparam int k_reg    = 0;
    localparam int k_imm    = 1;
    localparam int k_branch = 2;
    localparam int k_mem    = 3;
    localparam int k_jal    = 4;
    localparam int k_jalr   = 5;
    localparam int k_auipc  = 6;
    localparam int k_lui    = 7;
    localparam int k_x0     = 8;

    localparam logic [31:0] body_pc = 32'd8;  // after the uart address setup
    localparam int run_limit  = 40;
    localparam int row_cycles = 64;

    typedef struct packed {
        int          kind;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        int          n_exp;
        logic [31:0] exp_word;  // expected bytes, lsb first
    } row_t;

    wire                     clk;
    logic                    reset;
    logic                    prog_we;
    logic [`IMEM_ADDR_W-1:0] prog_addr;
    rv_core_pkg::inst_u      prog_data;
    wire                     uart_valid;
    wire  [7:0]              uart_data;

    row_t               rows[$];
    rv_core_pkg::inst_u prog[$];
    logic [7:0]         rx[$];
    logic               prev_valid;
    logic               table_ready;
    int                 seed;

    tb_clock #(.period(20)) clock_i (.o_clk(clk));

    rv_core dut_i (
        .clk(clk), .reset(reset),
        .i_prog_we(prog_we), .i_prog_addr(prog_addr), .i_prog_data(prog_data),
        .o_uart_valid(uart_valid), .o_uart_data(uart_data)
    );

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] want,
                              input int row, input int idx);
        if (got !== want) begin
            report_error($sformatf("row %0d byte %0d: got 0x%02h, expected 0x%02h",
                                   row, idx, got, want));
        end
    endtask

    task automatic check_count(input int got, input int want, input int row);
        if (got != want) begin
            report_error($sformatf("row %0d: %0d uart strobes, expected %0d", row, got, want));
        end
    endtask

    // rv32i reference results
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_extend(input logic [2:0] f3, input logic [31:0] w,
                                                input logic [1:0] off);
        logic [31:0] sh;
        sh = w >> {off, 3'b000};
        case (f3)
            3'd0: return {{24{sh[7]}}, sh[7:0]};
            3'd1: return {{16{sh[15]}}, sh[15:0]};
            3'd4: return {24'd0, sh[7:0]};
            3'd5: return {16'd0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic rv_core_pkg::inst_u r_type(input logic [6:0] f7,
            input logic [4:0] rs2, rs1, input logic [2:0] f3, input logic [4:0] rd);
        rv_core_pkg::inst_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = `OP_REG;
        return w;
    endfunction

    function automatic rv_core_pkg::inst_u i_type(input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        rv_core_pkg::inst_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic rv_core_pkg::inst_u s_type(input logic [11:0] imm,
            input logic [4:0] rs2, rs1, input logic [2:0] f3);
        rv_core_pkg::inst_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = f3;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = `OP_STORE;
        return w;
    endfunction

    function automatic rv_core_pkg::inst_u b_type(input logic [12:0] imm,
            input logic [4:0] rs2, rs1, input logic [2:0] f3);
        rv_core_pkg::inst_u w;
        w.b.imm_12   = imm[12];
        w.b.imm_10_5 = imm[10:5];
        w.b.rs2      = rs2;
        w.b.rs1      = rs1;
        w.b.funct3   = f3;
        w.b.imm_4_1  = imm[4:1];
        w.b.imm_11   = imm[11];
        w.b.opcode   = `OP_BRANCH;
        return w;
    endfunction

    function automatic rv_core_pkg::inst_u u_type(input logic [19:0] imm,
            input logic [4:0] rd, input logic [6:0] op);
        rv_core_pkg::inst_u w;
        w.u.imm    = imm;
        w.u.rd     = rd;
        w.u.opcode = op;
        return w;
    endfunction

    function automatic rv_core_pkg::inst_u j_type(input logic [20:0] imm, input logic [4:0] rd);
        rv_core_pkg::inst_u w;
        w.j.imm_20    = imm[20];
        w.j.imm_10_1  = imm[10:1];
        w.j.imm_11    = imm[11];
        w.j.imm_19_12 = imm[19:12];
        w.j.rd        = rd;
        w.j.opcode    = `OP_JAL;
        return w;
    endfunction

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] up;
        up = val + 32'h800;  // addi sign-extends the low part
        prog.push_back(u_type(up[31:12], rd, `OP_LUI));
        prog.push_back(i_type(val[11:0], rd, 3'b000, rd, `OP_IMM));
    endtask

    // four sb to the uart, lowest byte first
    task automatic send_word(input logic [4:0] rs);
        prog.push_back(s_type(12'd0, rs, 5'd31, 3'b000));
        for (int k = 1; k < 4; k++) begin
            prog.push_back(i_type(12'(8 * k), rs, 3'b101, 5'd5, `OP_IMM));
            prog.push_back(s_type(12'd0, 5'd5, 5'd31, 3'b000));
        end
    endtask

    task automatic build_program(input row_t r);
        load_imm(5'd31, `UART_TX_ADDR);
        case (r.kind)
            k_reg: begin
                load_imm(5'd1, r.a);
                load_imm(5'd2, r.b);
                prog.push_back(r_type(r.alt ? 7'h20 : 7'h00, 5'd2, 5'd1, r.f3, 5'd3));
                send_word(5'd3);
            end
            k_imm: begin
                load_imm(5'd1, r.a);
                prog.push_back(i_type(r.imm[11:0], 5'd1, r.f3, 5'd3, `OP_IMM));
                send_word(5'd3);
            end
            k_branch: begin
                load_imm(5'd1, r.a);
                load_imm(5'd2, r.b);
                prog.push_back(b_type(13'd12, 5'd2, 5'd1, r.f3));  // over the 0x01 marker
                prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd4, `OP_IMM));
                prog.push_back(s_type(12'd0, 5'd4, 5'd31, 3'b000));
                prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd4, `OP_IMM));
                prog.push_back(s_type(12'd0, 5'd4, 5'd31, 3'b000));
            end
            k_mem: begin
                load_imm(5'd1, r.a);
                load_imm(5'd2, 32'h100);
                prog.push_back(s_type(12'd0, 5'd1, 5'd2, 3'b010));
                prog.push_back(i_type(r.imm[11:0], 5'd2, r.f3, 5'd3, `OP_LOAD));
                send_word(5'd3);
            end
            k_jal: begin
                prog.push_back(j_type(21'd8, 5'd1));
                prog.push_back(s_type(12'd0, 5'd0, 5'd31, 3'b000));  // skipped
                send_word(5'd1);
            end
            k_jalr: begin
                // base + offset lands on 25, bit 0 cleared gives 24
                load_imm(5'd2, 32'd25 - {{20{r.imm[11]}}, r.imm[11:0]});
                prog.push_back(i_type(r.imm[11:0], 5'd2, 3'b000, 5'd1, `OP_JALR));
                prog.push_back(s_type(12'd0, 5'd0, 5'd31, 3'b000));
                send_word(5'd1);
            end
            k_auipc: begin
                prog.push_back(u_type(r.imm[19:0], 5'd3, `OP_AUIPC));
                send_word(5'd3);
            end
            k_lui: begin
                prog.push_back(u_type(r.imm[19:0], 5'd3, `OP_LUI));
                send_word(5'd3);
            end
            default: begin
                load_imm(5'd0, r.a);
                send_word(5'd0);
            end
        endcase
        prog.push_back(j_type(21'd0, 5'd0));  // park
    endtask

    task automatic add_row(input int kind, input logic [2:0] f3, input logic alt,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
        row_t r;
        r.kind  = kind;
        r.f3    = f3;
        r.alt   = alt;
        r.a     = a;
        r.b     = b;
        r.imm   = imm;
        r.n_exp = 4;
        case (kind)
            k_reg:   r.exp_word = alu_model(f3, alt, a, b);
            k_imm:   r.exp_word = alu_model(f3, alt, a, {{20{imm[11]}}, imm[11:0]});
            k_branch: begin
                r.n_exp    = branch_taken(f3, a, b) ? 1 : 2;
                r.exp_word = branch_taken(f3, a, b) ? 32'h02 : 32'h0201;
            end
            k_mem:   r.exp_word = load_extend(f3, a, imm[1:0]);
            k_jal:   r.exp_word = body_pc + 32'd4;
            k_jalr:  r.exp_word = body_pc + 32'd12;
            k_auipc: r.exp_word = body_pc + {imm[19:0], 12'h000};
            k_lui:   r.exp_word = {imm[19:0], 12'h000};
            default: r.exp_word = 32'd0;
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(k_reg, 3'd0, 1'b0, 32'h1234_5678, 32'h0fed_cba9, 32'd0);
        add_row(k_reg, 3'd0, 1'b0, $random(seed), $random(seed), 32'd0);
        add_row(k_reg, 3'd0, 1'b1, 32'd5, 32'd9, 32'd0);  // negative difference
        add_row(k_reg, 3'd1, 1'b0, $random(seed), 32'd13, 32'd0);
        add_row(k_reg, 3'd2, 1'b0, 32'hffff_fff0, 32'd3, 32'd0);
        add_row(k_reg, 3'd3, 1'b0, 32'hffff_fff0, 32'd3, 32'd0);
        add_row(k_reg, 3'd4, 1'b0, $random(seed), $random(seed), 32'd0);
        add_row(k_reg, 3'd5, 1'b0, 32'h8765_4321, 32'd7, 32'd0);
        add_row(k_reg, 3'd5, 1'b1, 32'h8765_4321, 32'd7, 32'd0);
        add_row(k_reg, 3'd6, 1'b0, $random(seed), $random(seed), 32'd0);
        add_row(k_reg, 3'd7, 1'b0, $random(seed), $random(seed), 32'd0);
        add_row(k_imm, 3'd0, 1'b0, $random(seed), 32'd0, 32'h800);
        add_row(k_imm, 3'd2, 1'b0, 32'hffff_fffe, 32'd0, 32'hfff);
        add_row(k_imm, 3'd3, 1'b0, 32'd5, 32'd0, 32'hfff);
        add_row(k_imm, 3'd4, 1'b0, $random(seed), 32'd0, 32'h5a5);
        add_row(k_imm, 3'd6, 1'b0, $random(seed), 32'd0, 32'h70f);
        add_row(k_imm, 3'd7, 1'b0, $random(seed), 32'd0, 32'h8f0);
        add_row(k_imm, 3'd1, 1'b0, $random(seed), 32'd0, 32'd5);
        add_row(k_imm, 3'd5, 1'b0, 32'hf000_00f0, 32'd0, 32'd4);
        add_row(k_imm, 3'd5, 1'b1, 32'hf000_00f0, 32'd0, 32'h404);
        add_row(k_branch, 3'd0, 1'b0, 32'h55, 32'h55, 32'd0);
        add_row(k_branch, 3'd0, 1'b0, 32'd1, 32'd2, 32'd0);
        add_row(k_branch, 3'd1, 1'b0, 32'd1, 32'd2, 32'd0);
        add_row(k_branch, 3'd4, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);
        add_row(k_branch, 3'd4, 1'b0, 32'd1, 32'hffff_ffff, 32'd0);
        add_row(k_branch, 3'd5, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);
        add_row(k_branch, 3'd5, 1'b0, 32'd7, 32'd7, 32'd0);
        add_row(k_branch, 3'd6, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);
        add_row(k_branch, 3'd7, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);
        add_row(k_mem, 3'd0, 1'b0, 32'h80f1_7f82, 32'd0, 32'd0);
        add_row(k_mem, 3'd0, 1'b0, 32'h80f1_7f82, 32'd0, 32'd1);
        add_row(k_mem, 3'd4, 1'b0, 32'h80f1_7f82, 32'd0, 32'd3);
        add_row(k_mem, 3'd1, 1'b0, 32'h80f1_7f82, 32'd0, 32'd2);
        add_row(k_mem, 3'd5, 1'b0, 32'h80f1_7f82, 32'd0, 32'd0);
        add_row(k_mem, 3'd2, 1'b0, $random(seed), 32'd0, 32'd0);
        add_row(k_jal, 3'd0, 1'b0, 32'd0, 32'd0, 32'd0);
        add_row(k_jalr, 3'd0, 1'b0, 32'd0, 32'd0, 32'd5);
        add_row(k_jalr, 3'd0, 1'b0, 32'd0, 32'd0, 32'hfff);
        add_row(k_auipc, 3'd0, 1'b0, 32'd0, 32'd0, 32'h12345);
        add_row(k_lui, 3'd0, 1'b0, 32'd0, 32'd0, 32'habcde);
        add_row(k_x0, 3'd0, 1'b0, 32'h1234_5abc, 32'd0, 32'd0);
    endtask

    task automatic run_row(input row_t r, input int idx);
        int cycles;
        prog.delete();
        build_program(r);
        @(posedge clk);
        #1;
        reset = 1'b1;
        rx.delete();
        for (int w = 0; w < prog.size(); w++) begin
            prog_we   = 1'b1;
            prog_addr = w[`IMEM_ADDR_W-1:0];
            prog_data = prog[w];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        reset  = 1'b0;
        cycles = 0;
        while (rx.size() < r.n_exp && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (4) @(posedge clk);  // room for a stray strobe
        check_count(rx.size(), r.n_exp, idx);
        for (int k = 0; k < r.n_exp; k++) begin
            check_byte(rx[k], r.exp_word[8*k +: 8], idx, k);
        end
    endtask

    // uart monitor, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (uart_valid === 1'b1) begin
                if (reset) report_error("uart strobe during reset or program load");
                if (prev_valid) report_error("uart strobe held for more than one cycle");
                rx.push_back(uart_data);
            end
            prev_valid = (uart_valid === 1'b1);
        end
    end

    initial begin
        wait (table_ready);
        #(rows.size() * row_cycles * 20);
        $display("timeout: the tests did not finish in the allowed time");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        prev_valid  = 1'b0;
        table_ready = 1'b0;
        seed        = 91;
        build_table();
        table_ready = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i], i);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int period = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(period / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_core (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_prog_we,
    input  wire [`IMEM_ADDR_W-1:0]   i_prog_addr,
    input  wire rv_core_pkg::inst_u  i_prog_data,
    output wire                      o_uart_valid,
    output wire [7:0]                o_uart_data
);

    wire [`XLEN-1:0]       pc;
    wire [`XLEN-1:0]       next_pc;
    rv_core_pkg::inst_u    inst;
    wire [`REG_ADDR_W-1:0] rs1;
    wire [`REG_ADDR_W-1:0] rs2;
    wire [`REG_ADDR_W-1:0] rd;
    wire [`XLEN-1:0]       imm;
    wire [`ALU_OP_W-1:0]   alu_op;
    wire [2:0]             funct3;
    wire                   use_imm;
    wire                   is_branch;
    wire                   is_jal;
    wire                   is_jalr;
    wire                   is_auipc;
    wire                   is_load;
    wire                   is_store;
    wire                   reg_we;
    wire [`XLEN-1:0]       rs1_data;
    wire [`XLEN-1:0]       rs2_data;
    wire [`XLEN-1:0]       alu_result;
    wire [`XLEN-1:0]       link;
    wire [`XLEN-1:0]       store_data;
    wire [3:0]             byte_en;

    rv_fetch fetch_i (
        .clk(clk), .reset(reset),
        .i_prog_we(i_prog_we), .i_prog_addr(i_prog_addr), .i_prog_data(i_prog_data),
        .i_next_pc(next_pc), .o_pc(pc), .o_inst(inst)
    );

    rv_decode decode_i (
        .i_inst(inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_funct3(funct3), .o_use_imm(use_imm),
        .o_is_branch(is_branch), .o_is_jal(is_jal), .o_is_jalr(is_jalr),
        .o_is_auipc(is_auipc), .o_is_load(is_load), .o_is_store(is_store),
        .o_reg_we(reg_we)
    );

    rv_execute execute_i (
        .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
        .i_alu_op(alu_op), .i_funct3(funct3), .i_use_imm(use_imm),
        .i_is_branch(is_branch), .i_is_jal(is_jal), .i_is_jalr(is_jalr),
        .i_is_auipc(is_auipc), .o_alu_result(alu_result), .o_link(link),
        .o_store_data(store_data), .o_next_pc(next_pc), .o_byte_en(byte_en)
    );

    rv_result result_i (
        .clk(clk), .reset(reset), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_is_load(is_load), .i_is_store(is_store), .i_reg_we(reg_we),
        .i_is_link(is_jal | is_jalr),  // jumps write pc+4
        .i_funct3(funct3), .i_alu_result(alu_result), .i_link(link),
        .i_store_data(store_data), .i_byte_en(byte_en),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .o_uart_valid(o_uart_valid), .o_uart_data(o_uart_data)
    );

endmodule

`default_nettype wire

// ==== verilog/rv_result.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_result (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`REG_ADDR_W-1:0]   i_rs1,
    input  wire [`REG_ADDR_W-1:0]   i_rs2,
    input  wire [`REG_ADDR_W-1:0]   i_rd,
    input  wire                     i_is_load,
    input  wire                     i_is_store,
    input  wire                     i_reg_we,
    input  wire                     i_is_link,
    input  wire [2:0]               i_funct3,
    input  wire [`XLEN-1:0]         i_alu_result,
    input  wire [`XLEN-1:0]         i_link,
    input  wire [`XLEN-1:0]         i_store_data,
    input  wire [3:0]               i_byte_en,
    output logic [`XLEN-1:0]        o_rs1_data,
    output logic [`XLEN-1:0]        o_rs2_data,
    output logic                    o_uart_valid,
    output logic [7:0]              o_uart_data
);

    logic [`XLEN-1:0] regs [1:31];
    logic [`XLEN-1:0] dmem [0:(1 << `DMEM_ADDR_W)-1];

    logic [`DMEM_ADDR_W-1:0] dmem_idx;
    logic                    in_dmem;
    logic                    uart_hit;
    logic [`XLEN-1:0]        mem_word;
    logic [7:0]              ld_byte;
    logic [15:0]             ld_half;
    logic [`XLEN-1:0]        load_data;
    logic [`XLEN-1:0]        wb_data;

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    assign dmem_idx = i_alu_result[`DMEM_ADDR_W+1:2];
    assign in_dmem  = (i_alu_result >> (`DMEM_ADDR_W + 2)) == '0;
    assign uart_hit = i_is_store && (i_funct3 == 3'b000) && (i_alu_result == `UART_TX_ADDR);

    always_ff @(posedge clk) begin
        if (!reset && i_is_store && in_dmem) begin
            for (int b = 0; b < 4; b++) begin
                if (i_byte_en[b]) begin
                    dmem[dmem_idx][8*b +: 8] <= i_store_data[8*b +: 8];
                end
            end
        end
    end

    // uart strobe, one cycle after the store
    always_ff @(posedge clk) begin
        if (reset) begin
            o_uart_valid <= 1'b0;
        end else begin
            o_uart_valid <= uart_hit;
        end
        if (uart_hit) begin
            o_uart_data <= i_store_data[7:0];
        end
    end

    assign mem_word = dmem[dmem_idx];
    assign ld_byte  = mem_word[8*i_alu_result[1:0] +: 8];
    assign ld_half  = i_alu_result[1] ? mem_word[31:16] : mem_word[15:0];

    always_comb begin
        case (i_funct3)
            3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};
            3'b001:  load_data = {{16{ld_half[15]}}, ld_half};
            3'b100:  load_data = {24'd0, ld_byte};
            3'b101:  load_data = {16'd0, ld_half};
            default: load_data = mem_word;
        endcase
    end

    assign wb_data = i_is_load ? load_data : (i_is_link ? i_link : i_alu_result);

    always_ff @(posedge clk) begin
        if (!reset && i_reg_we && i_rd != '0) begin
            regs[i_rd] <= wb_data;
        end
    end

    // address comes from execute, width from decode
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        (i_is_load || i_is_store) && i_funct3[1:0] == 2'b10 |-> i_alu_result[1:0] == 2'b00);

    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        (i_is_load || i_is_store) && i_funct3[1:0] == 2'b01 |-> !i_alu_result[0]);

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_execute (
    input  wire [`XLEN-1:0]      i_pc,
    input  wire [`XLEN-1:0]      i_rs1_data,
    input  wire [`XLEN-1:0]      i_rs2_data,
    input  wire [`XLEN-1:0]      i_imm,
    input  wire [`ALU_OP_W-1:0]  i_alu_op,
    input  wire [2:0]            i_funct3,
    input  wire                  i_use_imm,
    input  wire                  i_is_branch,
    input  wire                  i_is_jal,
    input  wire                  i_is_jalr,
    input  wire                  i_is_auipc,
    output logic [`XLEN-1:0]     o_alu_result,
    output logic [`XLEN-1:0]     o_link,
    output logic [`XLEN-1:0]     o_store_data,
    output logic [`XLEN-1:0]     o_next_pc,
    output logic [3:0]           o_byte_en
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] pc_rel;
    logic             taken;

    assign op_a  = i_is_auipc ? i_pc : i_rs1_data;
    assign op_b  = i_use_imm ? i_imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            `ALU_SUB:    o_alu_result = op_a - op_b;
            `ALU_SLL:    o_alu_result = op_a << shamt;
            `ALU_SLT:    o_alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU:   o_alu_result = {31'd0, op_a < op_b};
            `ALU_XOR:    o_alu_result = op_a ^ op_b;
            `ALU_SRL:    o_alu_result = op_a >> shamt;
            `ALU_SRA:    o_alu_result = $signed(op_a) >>> shamt;
            `ALU_OR:     o_alu_result = op_a | op_b;
            `ALU_AND:    o_alu_result = op_a & op_b;
            `ALU_PASS_B: o_alu_result = op_b;
            default:     o_alu_result = op_a + op_b;
        endcase
    end

    // branch condition on the raw register values
    always_comb begin
        case (i_funct3)
            3'b000:  taken = (i_rs1_data == i_rs2_data);
            3'b001:  taken = (i_rs1_data != i_rs2_data);
            3'b100:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
            3'b101:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
            3'b110:  taken = i_rs1_data < i_rs2_data;
            3'b111:  taken = i_rs1_data >= i_rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = i_pc + 32'd4;
    assign pc_rel   = i_pc + i_imm;  // branch and jal target
    assign o_link   = pc_plus4;

    always_comb begin
        if (i_is_jalr) begin
            o_next_pc = {o_alu_result[`XLEN-1:1], 1'b0};
        end else if (i_is_jal || (i_is_branch && taken)) begin
            o_next_pc = pc_rel;
        end else begin
            o_next_pc = pc_plus4;
        end
    end

    // store lanes; data is replicated so every enabled lane sees it
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                o_byte_en    = 4'b0001 << o_alu_result[1:0];
                o_store_data = {4{i_rs2_data[7:0]}};
            end
            2'b01: begin
                o_byte_en    = 4'b0011 << {o_alu_result[1], 1'b0};
                o_store_data = {2{i_rs2_data[15:0]}};
            end
            default: begin
                o_byte_en    = 4'b1111;
                o_store_data = i_rs2_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_decode (
    input  wire rv_core_pkg::inst_u   i_inst,
    output logic [`REG_ADDR_W-1:0]    o_rs1,
    output logic [`REG_ADDR_W-1:0]    o_rs2,
    output logic [`REG_ADDR_W-1:0]    o_rd,
    output logic [`XLEN-1:0]          o_imm,
    output logic [`ALU_OP_W-1:0]      o_alu_op,
    output logic [2:0]                o_funct3,
    output logic                      o_use_imm,
    output logic                      o_is_branch,
    output logic                      o_is_jal,
    output logic                      o_is_jalr,
    output logic                      o_is_auipc,
    output logic                      o_is_load,
    output logic                      o_is_store,
    output logic                      o_reg_we
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       alt;     // sub / sra select

    assign opcode   = i_inst.r.opcode;
    assign funct3   = i_inst.r.funct3;
    assign funct7   = i_inst.r.funct7;
    assign alt      = funct7[5];
    assign o_rs1    = i_inst.r.rs1;
    assign o_rs2    = i_inst.r.rs2;
    assign o_rd     = i_inst.r.rd;
    assign o_funct3 = funct3;

    // immediate by format
    always_comb begin
        case (opcode)
            `OP_STORE:  o_imm = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
            `OP_BRANCH: o_imm = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                                 i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
            `OP_LUI, `OP_AUIPC: o_imm = {i_inst.u.imm, 12'h000};
            `OP_JAL:    o_imm = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                                 i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
            default:    o_imm = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
        endcase
    end

    always_comb begin
        legal    = 1'b0;
        o_alu_op = `ALU_ADD;  // address and link adds
        case (opcode)
            `OP_LUI: begin
                legal    = 1'b1;
                o_alu_op = `ALU_PASS_B;
            end
            `OP_AUIPC, `OP_JAL: legal = 1'b1;
            `OP_JALR:   legal = (funct3 == 3'b000);
            `OP_BRANCH: legal = (funct3[2:1] != 2'b01);
            `OP_LOAD:   legal = (funct3 != 3'b011) && (funct3 < 3'b110);
            `OP_STORE:  legal = (funct3 < 3'b011);
            `OP_IMM, `OP_REG: begin
                if (opcode == `OP_REG || funct3 == 3'b001 || funct3 == 3'b101) begin
                    // funct7 only matters for shifts and register ops
                    legal = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                             (funct3 == 3'b000 && opcode == `OP_REG)));
                end else begin
                    legal = 1'b1;
                end
                case (funct3)
                    3'b000:  o_alu_op = (opcode == `OP_REG && alt) ? `ALU_SUB : `ALU_ADD;
                    3'b001:  o_alu_op = `ALU_SLL;
                    3'b010:  o_alu_op = `ALU_SLT;
                    3'b011:  o_alu_op = `ALU_SLTU;
                    3'b100:  o_alu_op = `ALU_XOR;
                    3'b101:  o_alu_op = alt ? `ALU_SRA : `ALU_SRL;
                    3'b110:  o_alu_op = `ALU_OR;
                    default: o_alu_op = `ALU_AND;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    assign o_use_imm   = (opcode != `OP_REG) && (opcode != `OP_BRANCH);
    assign o_is_branch = legal && (opcode == `OP_BRANCH);
    assign o_is_jal    = legal && (opcode == `OP_JAL);
    assign o_is_jalr   = legal && (opcode == `OP_JALR);
    assign o_is_auipc  = legal && (opcode == `OP_AUIPC);
    assign o_is_load   = legal && (opcode == `OP_LOAD);
    assign o_is_store  = legal && (opcode == `OP_STORE);
    assign o_reg_we    = legal && (opcode != `OP_BRANCH) && (opcode != `OP_STORE);

endmodule

`default_nettype wire

// ==== verilog/rv_fetch.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "rv_core_consts.svh"

module rv_fetch (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_prog_we,
    input  wire [`IMEM_ADDR_W-1:0]   i_prog_addr,
    input  wire rv_core_pkg::inst_u  i_prog_data,
    input  wire [`XLEN-1:0]          i_next_pc,
    output logic [`XLEN-1:0]         o_pc,
    output rv_core_pkg::inst_u       o_inst
);

    logic [`XLEN-1:0] pc;
    rv_core_pkg::inst_u imem [0:(1 << `IMEM_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= i_next_pc;
        end
    end

    // program load, one word per clock
    always_ff @(posedge clk) begin
        if (i_prog_we) begin
            imem[i_prog_addr] <= i_prog_data;
        end
    end

    assign o_pc   = pc;
    assign o_inst = imem[pc[`IMEM_ADDR_W+1:2]];  // async read

    // jump targets from execute must keep the pc on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

    a_load_in_reset: assert property (@(posedge clk) i_prog_we |-> reset);

endmodule

`default_nettype wire

// ==== verilog/rv_core_pkg.sv ====
`default_nettype none
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;  // imm[11:5]
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;  // imm[4:0]
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;     // imm[31:12]
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    // one instruction word, seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

`default_nettype wire

// ==== verilog/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define XLEN          32
`define REG_ADDR_W    5
`define IMEM_ADDR_W   10
`define DMEM_ADDR_W   10
`define UART_TX_ADDR  32'h0001_0000  // above the 4 KB data range

// major opcodes
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_IMM     7'b0010011
`define OP_REG     7'b0110011

`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_PASS_B  4'd10

`endif
